// File: hdl/dds_macros.svh
`ifndef DDS_MACROS_SVH
`define DDS_MACROS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
`define DDS_PHASE_W        32          // phase accumulator
`define DDS_SAMPLE_W       12          // signed output samples
`define DDS_TABLE_BITS     8           // sine table index, top phase bits
`define DDS_SAMPLE_MAX     2047        // full scale

////////////////////////////////////////
// bit source
////////////////////////////////////////
`define DDS_LFSR_TICK_DIV  1000        // clocks per lfsr step
`define DDS_LFSR_W         5
`define DDS_LFSR_SEED      5'b00001

// x^5 + x^3 + 1, fibonacci form
`define DDS_LFSR_TAP_HI    4
`define DDS_LFSR_TAP_LO    2

`endif

// File: hdl/dds_pkg.sv
`include "dds_macros.svh"

package dds_pkg;

   // one signed output sample
   typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;

   // plain waveform on wave_out
   typedef enum logic [1:0] {
      WAVE_SINE   = 2'b00,
      WAVE_COSINE = 2'b01,
      WAVE_SAW    = 2'b10,
      WAVE_SQUARE = 2'b11
   } wave_sel_e;

   // keying scheme on mod_out
   typedef enum logic [1:0] {
      MOD_ASK        = 2'b00,
      MOD_FSK        = 2'b01,
      MOD_BPSK       = 2'b10,
      MOD_LFSR_LEVEL = 2'b11
   } mod_sel_e;

   // all four generator outputs, 48 bits
   typedef struct packed {
      sample_t sine;
      sample_t cosine;
      sample_t square;
      sample_t saw;
   } waves_t;

   // tuning words, word 0 means no phase advance
   typedef struct packed {
      logic [`DDS_PHASE_W-1:0] base_word;
      logic [`DDS_PHASE_W-1:0] mark_word;  // fsk, used while the bit is 1
   } tune_cfg_t;

   typedef struct packed {
      wave_sel_e wave_sel;
      mod_sel_e  mod_sel;
   } mode_cfg_t;

endpackage

// File: hdl/config_receiver.sv
`timescale 1ns/100ps

module config_receiver #(
   parameter type payload_t = logic
) (
   input  logic     video_clk_40Mhz,
   input  logic     reset_from_key,
   input  logic     req,
   input  payload_t data,
   output logic     ack,
   output payload_t cfg
);

   typedef enum logic {
      RX_IDLE,
      RX_ACK
   } rx_state_e;

   rx_state_e state;

   ////////////////////////////////////////
   // four-phase ack machine
   ////////////////////////////////////////
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         state <= RX_IDLE;
         cfg   <= '0;                   // zero config, sine / ask / word 0
      end else begin
         case (state)
            RX_IDLE: begin
               if (req) begin
                  cfg   <= data;          // host holds data stable with req
                  state <= RX_ACK;
               end
            end
            RX_ACK: begin
               // hold ack until the host lets go of req
               if (!req) begin
                  state <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // new cfg and ack appear on the same edge
   assign ack = (state == RX_ACK);

endmodule

// File: hdl/dds_waveform_gen.sv
`timescale 1ns/100ps
`include "dds_macros.svh"

module dds_waveform_gen import dds_pkg::*; (
   input  logic                    video_clk_40Mhz,
   input  logic                    reset_from_key,
   input  logic [`DDS_PHASE_W-1:0] phase_inc,
   output waves_t                  waves
);

   localparam int  TABLE_SIZE = 1 << `DDS_TABLE_BITS;
   localparam real PI         = 3.14159265358979323846;

   logic    [`DDS_PHASE_W-1:0]    phase;
   logic    [`DDS_TABLE_BITS-1:0] sin_idx;
   logic    [`DDS_TABLE_BITS-1:0] cos_idx;
   logic    [`DDS_SAMPLE_W-1:0]   phase_top;
   sample_t                       sine_rom [TABLE_SIZE];
   sample_t                       square_next;
   sample_t                       saw_next;

   ////////////////////////////////////////
   // sine table
   ////////////////////////////////////////

   // one full period, rounded to nearest
   initial begin
      real angle;
      real scaled;
      for (int i = 0; i < TABLE_SIZE; i++) begin
         angle       = 2.0 * PI * i / TABLE_SIZE;
         scaled      = `DDS_SAMPLE_MAX * $sin(angle);
         sine_rom[i] = sample_t'($rtoi(scaled >= 0.0 ? scaled + 0.5 : scaled - 0.5));
      end
   end

   ////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         phase <= '0;
      end else begin
         phase <= phase + phase_inc;      // wraps freely
      end
   end

   assign sin_idx   = phase[`DDS_PHASE_W-1 -: `DDS_TABLE_BITS];
   assign cos_idx   = sin_idx + `DDS_TABLE_BITS'(TABLE_SIZE / 4);  // quarter turn ahead
   assign phase_top = phase[`DDS_PHASE_W-1 -: `DDS_SAMPLE_W];

   // first half of the period high, second half low
   assign square_next = phase[`DDS_PHASE_W-1] ? -sample_t'(`DDS_SAMPLE_MAX)
                                              : sample_t'(`DDS_SAMPLE_MAX);

   // offset binary to two's complement
   assign saw_next = sample_t'(phase_top - `DDS_SAMPLE_W'(`DDS_SAMPLE_MAX + 1));

   ////////////////////////////////////////
   // waveform registers
   ////////////////////////////////////////
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         waves <= '0;
      end else begin
         waves.sine   <= sine_rom[sin_idx];
         waves.cosine <= sine_rom[cos_idx];
         waves.square <= square_next;
         waves.saw    <= saw_next;
      end
   end

endmodule

// File: hdl/lfsr_bit_source.sv
`timescale 1ns/100ps
`include "dds_macros.svh"

module lfsr_bit_source (
   input  logic video_clk_40Mhz,
   input  logic reset_from_key,
   output logic lfsr_bit
);

   localparam int CNT_W = $clog2(`DDS_LFSR_TICK_DIV);

   logic [CNT_W-1:0]        tick_cnt;
   logic                    tick;
   logic [`DDS_LFSR_W-1:0]  lfsr;
   logic                    feedback;

   ////////////////////////////////////////
   // step divider
   ////////////////////////////////////////

   // single-cycle enable, no derived clock
   assign tick = (tick_cnt == CNT_W'(`DDS_LFSR_TICK_DIV - 1));

   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         tick_cnt <= '0;
      end else if (tick) begin
         tick_cnt <= '0;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // 5-bit fibonacci lfsr
   ////////////////////////////////////////
   assign feedback = lfsr[`DDS_LFSR_TAP_HI] ^ lfsr[`DDS_LFSR_TAP_LO];

   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         lfsr <= `DDS_LFSR_SEED;          // must not be all zeros
      end else if (tick) begin
         lfsr <= {lfsr[`DDS_LFSR_W-2:0], feedback};  // period 31
      end
   end

   assign lfsr_bit = lfsr[0];

endmodule

// File: hdl/keying_modulator.sv
`timescale 1ns/100ps
`include "dds_macros.svh"

module keying_modulator import dds_pkg::*; (
   input  logic                    video_clk_40Mhz,
   input  logic                    reset_from_key,
   input  tune_cfg_t               tune,
   input  mode_cfg_t               mode,
   input  logic                    lfsr_bit,
   input  waves_t                  waves,
   output logic [`DDS_PHASE_W-1:0] phase_inc,
   output sample_t                 mod_out,
   output sample_t                 wave_out,
   output logic                    lfsr_out
);

   logic bit_d;     // lines up with waves

   // fsk switches the word, every other mode runs on the base word
   assign phase_inc = (mode.mod_sel == MOD_FSK && lfsr_bit) ? tune.mark_word
                                                            : tune.base_word;

   ////////////////////////////////////////
   // keyed output
   ////////////////////////////////////////
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         bit_d    <= 1'b0;
         lfsr_out <= 1'b0;
         mod_out  <= '0;
      end else begin
         bit_d    <= lfsr_bit;
         lfsr_out <= bit_d;                 // same cycle as mod_out
         case (mode.mod_sel)
            MOD_ASK:  mod_out <= bit_d ? waves.sine : '0;
            MOD_FSK:  mod_out <= waves.sine;   // keying is in the phase step
            MOD_BPSK: mod_out <= bit_d ? waves.sine : ~waves.sine;
            MOD_LFSR_LEVEL: begin
               // raw bit as a level, 0 or the msb alone
               mod_out <= bit_d ? '0 : sample_t'(1 << (`DDS_SAMPLE_W - 1));
            end
            default: mod_out <= '0;
         endcase
      end
   end

   ////////////////////////////////////////
   // plain waveform output
   ////////////////////////////////////////
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         wave_out <= '0;
      end else begin
         case (mode.wave_sel)
            WAVE_SINE:   wave_out <= waves.sine;
            WAVE_COSINE: wave_out <= waves.cosine;
            WAVE_SAW:    wave_out <= waves.saw;
            WAVE_SQUARE: wave_out <= waves.square;
            default:     wave_out <= '0;
         endcase
      end
   end

endmodule

// File: hdl/dds_modulation_top.sv
`timescale 1ns/100ps
`include "dds_macros.svh"

module dds_modulation_top import dds_pkg::*; (
   input  logic      video_clk_40Mhz,
   input  logic      reset_from_key,
   input  logic      tune_req,
   input  tune_cfg_t tune_data,
   output logic      tune_ack,
   input  logic      mode_req,
   input  mode_cfg_t mode_data,
   output logic      mode_ack,
   output sample_t   mod_out,
   output sample_t   wave_out,
   output logic      lfsr_out
);

   tune_cfg_t               tune_cfg;
   mode_cfg_t               mode_cfg;
   logic                    lfsr_bit;
   logic [`DDS_PHASE_W-1:0] phase_inc;
   waves_t                  waves;

   ////////////////////////////////////////
   // host configuration ports
   ////////////////////////////////////////
   config_receiver #(.payload_t(tune_cfg_t)) u_tune_rx (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .req             (tune_req),
      .data            (tune_data),
      .ack             (tune_ack),
      .cfg             (tune_cfg)
   );

   config_receiver #(.payload_t(mode_cfg_t)) u_mode_rx (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .req             (mode_req),
      .data            (mode_data),
      .ack             (mode_ack),
      .cfg             (mode_cfg)
   );

   ////////////////////////////////////////
   // bit source, generator, keying
   ////////////////////////////////////////
   lfsr_bit_source u_lfsr (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .lfsr_bit        (lfsr_bit)
   );

   dds_waveform_gen u_waves (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .phase_inc       (phase_inc),
      .waves           (waves)
   );

   keying_modulator u_keying (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .tune            (tune_cfg),
      .mode            (mode_cfg),
      .lfsr_bit        (lfsr_bit),
      .waves           (waves),
      .phase_inc       (phase_inc),   // loops back to the accumulator
      .mod_out         (mod_out),
      .wave_out        (wave_out),
      .lfsr_out        (lfsr_out)
   );

endmodule

// File: verification/dds_modulation_sva.sv
`timescale 1ns/100ps

module dds_modulation_sva (
   input logic video_clk_40Mhz,
   input logic reset_from_key,
   input logic req,
   input logic ack
);

   ////////////////////////////////////////
   // four-phase handshake
   ////////////////////////////////////////

   // ack only answers a pending req
   ack_needs_req: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      $rose(ack) |-> $past(req))
      else $error("ack rose without a req before it");

   ack_falls_after_req: assert property (@(posedge video_clk_40Mhz)
      disable iff (reset_from_key)
      $fell(ack) |-> $past(!req))
      else $error("ack fell while req was still high");

   ack_holds: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      (ack && req) |=> ack)       // held for the whole req
      else $error("ack dropped while req was high");

   ////////////////////////////////////////
   // reset
   ////////////////////////////////////////
   ack_low_after_reset: assert property (@(posedge video_clk_40Mhz)
      reset_from_key |=> !ack)
      else $error("ack high after a reset clock");

endmodule

bind config_receiver dds_modulation_sva i_handshake_sva (
   .video_clk_40Mhz (video_clk_40Mhz),
   .reset_from_key  (reset_from_key),
   .req             (req),
   .ack             (ack)
);

// File: verification/dds_modulation_tb.sv
`timescale 1ns/100ps
`include "dds_macros.svh"

module dds_modulation_tb import dds_pkg::*; ();

   localparam int CLK_PERIOD = 100;
   localparam int SETTLE     = 4;          // config to clean outputs, with margin
   localparam int TABLE_SIZE = 1 << `DDS_TABLE_BITS;

   logic      video_clk_40Mhz;
   logic      reset_from_key;
   logic      tune_req;
   tune_cfg_t tune_data;
   logic      tune_ack;
   logic      mode_req;
   mode_cfg_t mode_data;
   logic      mode_ack;
   sample_t   mod_out;
   sample_t   wave_out;
   logic      lfsr_out;

   sample_t   sine_ref [TABLE_SIZE];
   int        edge_cnt;                    // clock edges since reset release
   int        limit_cycles;
   int        errors;
   int        checks;
   int        test_errors;
   string     cur_name;

   // one entry per stimulus line
   string       t_name  [$];
   mod_sel_e    t_mod   [$];
   wave_sel_e   t_wave  [$];
   logic [31:0] t_base  [$];
   logic [31:0] t_mark  [$];
   int          t_count [$];
   int          t_bstep [$];
   int          t_mstep [$];

   dds_modulation_top i_dut (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .tune_req        (tune_req),
      .tune_data       (tune_data),
      .tune_ack        (tune_ack),
      .mode_req        (mode_req),
      .mode_data       (mode_data),
      .mode_ack        (mode_ack),
      .mod_out         (mod_out),
      .wave_out        (wave_out),
      .lfsr_out        (lfsr_out)
   );

   initial video_clk_40Mhz = 1'b0;
   always #(CLK_PERIOD / 2) video_clk_40Mhz = ~video_clk_40Mhz;

   always @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         edge_cnt <= 0;
      end else begin
         edge_cnt <= edge_cnt + 1;
      end
   end

   // round(2047 sin(2 pi i / 256))
   initial begin
      real a;
      for (int i = 0; i < TABLE_SIZE; i++) begin
         a = `DDS_SAMPLE_MAX * $sin(2.0 * 3.14159265358979 * i / TABLE_SIZE);
         sine_ref[8'(i)] = sample_t'($rtoi(a < 0.0 ? a - 0.5 : a + 0.5));
      end
   end

   ////////////////////////////////////////
   // reference model and reporting
   ////////////////////////////////////////

   // lfsr_out two clocks behind a step every tick_div clocks
   function automatic logic lfsr_expected(input int e);
      logic [4:0] r;
      int         steps;
      if (e < 2) begin
         return 1'b0;
      end
      steps = (e - 2) / `DDS_LFSR_TICK_DIV;
      r     = `DDS_LFSR_SEED;
      for (int k = 0; k < steps; k++) begin
         r = {r[3:0], r[4] ^ r[2]};        // x^5 + x^3 + 1
      end
      return r[0];
   endfunction

   function automatic logic port_ack(input logic is_tune);
      return is_tune ? tune_ack : mode_ack;
   endfunction

   task automatic report_mismatch(input string what, input int exp, input int act);
      errors++;
      test_errors++;
      $display("FAIL %0s %0s expected %0d actual %0d", cur_name, what, exp, act);
   endtask

   task automatic report_problem(input string msg);
      errors++;
      test_errors++;
      $display("%0s: %0s", cur_name, msg);
   endtask

   task automatic read_stim();
      int          fd;
      string       line;
      string       name;
      int          mod_v;
      int          wave_v;
      int          cnt_v;
      int          bstep_v;
      int          mstep_v;
      logic [31:0] base_v;
      logic [31:0] mark_v;
      cur_name = "stimulus";
      fd = $fopen("verification/dds_modulation_stim.txt", "r");
      if (fd == 0) begin
         report_problem("cannot open verification/dds_modulation_stim.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line.getc(0) != "#") begin     // skip notes and blanks
            if ($sscanf(line, "%s %d %d %h %h %d %d %d", name, mod_v, wave_v, base_v,
                        mark_v, cnt_v, bstep_v, mstep_v) == 8) begin
               t_name.push_back(name);
               t_mod.push_back(mod_sel_e'(mod_v[1:0]));
               t_wave.push_back(wave_sel_e'(wave_v[1:0]));
               t_base.push_back(base_v);
               t_mark.push_back(mark_v);
               t_count.push_back(cnt_v);
               t_bstep.push_back(bstep_v);
               t_mstep.push_back(mstep_v);
            end else begin
               report_problem({"unreadable stimulus line ", line});
            end
         end
      end
      $fclose(fd);
   endtask

   ////////////////////////////////////////
   // host side of the config ports
   ////////////////////////////////////////
   task automatic send_config(input logic is_tune, input tune_cfg_t t, input mode_cfg_t m);
      int waited;
      repeat ($urandom % 4) @(negedge video_clk_40Mhz);   // random idle gap
      if (is_tune) begin
         tune_data = t;
         tune_req  = 1'b1;
      end else begin
         mode_data = m;
         mode_req  = 1'b1;
      end
      waited = 0;
      while (!port_ack(is_tune) && waited < 3) begin
         @(negedge video_clk_40Mhz);
         waited++;
      end
      checks++;
      if (!port_ack(is_tune) || waited > 2) begin
         report_problem("ack did not rise within two clocks of req");
      end
      @(negedge video_clk_40Mhz);
      if (!port_ack(is_tune)) begin
         report_problem("ack dropped while req was still high");
      end
      if (is_tune) begin
         tune_req = 1'b0;
      end else begin
         mode_req = 1'b0;
      end
      waited = 0;
      while (port_ack(is_tune) && waited < 3) begin
         @(negedge video_clk_40Mhz);
         waited++;
      end
      if (port_ack(is_tune) || waited > 2) begin
         report_problem("ack stayed high more than two clocks after req fell");
      end
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////
   task automatic check_reset();
      cur_name    = "reset";
      test_errors = 0;
      checks++;
      if (tune_ack !== 1'b0) begin
         report_mismatch("tune_ack in reset", 0, int'(tune_ack));
      end
      if (mode_ack !== 1'b0) begin
         report_mismatch("mode_ack in reset", 0, int'(mode_ack));
      end
      reset_from_key = 1'b0;
      for (int k = 0; k < 2; k++) begin      // pipeline still filling
         checks++;
         if (mod_out !== '0) begin
            report_mismatch("mod_out while filling", 0, int'(mod_out));
         end
         if (wave_out !== '0) begin
            report_mismatch("wave_out while filling", 0, int'(wave_out));
         end
         if (lfsr_out !== 1'b0) begin
            report_mismatch("lfsr_out while filling", 0, int'(lfsr_out));
         end
         @(negedge video_clk_40Mhz);
      end
      checks++;
      if (lfsr_out !== 1'b1) begin
         report_mismatch("lfsr_out after fill", 1, int'(lfsr_out));
      end
      $display("test reset: %0d errors", test_errors);
   endtask

   task automatic run_test(input int i);
      tune_cfg_t  t;
      mode_cfg_t  m;
      logic [7:0] idx;
      sample_t    s_ref;
      sample_t    exp_mod;
      sample_t    exp_wave;
      logic       bit_prev;
      int         p;
      int         p_new;
      int         p0;
      int         c0;
      int         step;
      int         since_change;
      cur_name    = t_name[i];
      test_errors = 0;
      t.base_word = t_base[i];
      t.mark_word = t_mark[i];
      m.mod_sel   = t_mod[i];
      m.wave_sel  = WAVE_SAW;                // saw first to read the phase
      send_config(1'b1, t, m);
      send_config(1'b0, t, m);
      repeat (SETTLE) @(negedge video_clk_40Mhz);
      p = int'(wave_out) + 2048;

      // constant step here, so carry the phase across the reselect
      if (t_wave[i] != WAVE_SAW) begin
         p0         = p;
         c0         = edge_cnt;
         m.wave_sel = t_wave[i];
         send_config(1'b0, t, m);
         repeat (SETTLE) @(negedge video_clk_40Mhz);
         p = (p0 + t_bstep[i] * (edge_cnt - c0)) % 4096;
      end

      since_change = 2;
      bit_prev     = lfsr_out;
      for (int n = 0; n < t_count[i]; n++) begin
         if (n > 0) begin
            @(negedge video_clk_40Mhz);
         end
         checks++;
         if (lfsr_out !== lfsr_expected(edge_cnt)) begin
            report_mismatch("lfsr_out", int'(lfsr_expected(edge_cnt)), int'(lfsr_out));
         end
         since_change = (lfsr_out != bit_prev) ? 0 : since_change + 1;
         bit_prev     = lfsr_out;

         if (m.wave_sel == WAVE_SAW) begin
            p_new = int'(wave_out) + 2048;
            step  = (m.mod_sel == MOD_FSK && lfsr_out) ? t_mstep[i] : t_bstep[i];
            // a bit change can leave the old word on two samples
            if (n > 0 && since_change >= 2 && (p_new - p + 4096) % 4096 != step) begin
               report_mismatch("saw step", step, (p_new - p + 4096) % 4096);
            end
            p = p_new;
         end else if (n > 0) begin
            p = (p + t_bstep[i]) % 4096;
         end

         idx   = 8'(p >> 4);                 // top 8 of the 12 saw bits
         s_ref = sine_ref[idx];

         // saw itself is covered by the step check
         if (m.wave_sel != WAVE_SAW) begin
            case (m.wave_sel)
               WAVE_COSINE: exp_wave = sine_ref[idx + 8'd64];
               WAVE_SQUARE: exp_wave = (p < 2048) ? sample_t'(`DDS_SAMPLE_MAX)
                                                  : sample_t'(-`DDS_SAMPLE_MAX);
               default:     exp_wave = s_ref;
            endcase
            if (wave_out !== exp_wave) begin
               report_mismatch("wave_out", int'(exp_wave), int'(wave_out));
            end
         end

         case (m.mod_sel)
            MOD_ASK:        exp_mod = lfsr_out ? s_ref : sample_t'(0);
            MOD_BPSK:       exp_mod = lfsr_out ? s_ref : ~s_ref;
            MOD_LFSR_LEVEL: exp_mod = lfsr_out ? sample_t'(0) : sample_t'(12'h800);
            default:        exp_mod = s_ref;   // fsk keys the frequency only
         endcase
         if (mod_out !== exp_mod) begin
            report_mismatch("mod_out", int'(exp_mod), int'(mod_out));
         end
      end
      $display("test %0s: %0d samples, %0d errors", cur_name, t_count[i], test_errors);
   endtask

   ////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////
   initial begin
      int total;
      void'($urandom(16251));
      reset_from_key = 1'b1;
      tune_req       = 1'b0;
      tune_data      = '0;
      mode_req       = 1'b0;
      mode_data      = '0;
      errors         = 0;
      checks         = 0;
      total          = 0;
      read_stim();
      if (t_name.size() == 0) begin
         report_problem("no test lines in the stimulus file");
      end
      foreach (t_count[i]) begin
         total += t_count[i];
      end
      limit_cycles = 2 * (total + 80 * t_count.size() + 20);   // handshakes and settling
      repeat (2) @(negedge video_clk_40Mhz);
      check_reset();
      for (int i = 0; i < t_name.size(); i++) begin
         run_test(i);
      end
      $display("%0d tests, %0d checks, %0d errors", t_name.size() + 1, checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge video_clk_40Mhz);
      $display("watchdog expired after %0d clocks, the run did not finish", limit_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: dds_modulation_top.f
+incdir+hdl
hdl/dds_pkg.sv
hdl/config_receiver.sv
hdl/dds_waveform_gen.sv
hdl/lfsr_bit_source.sv
hdl/keying_modulator.sv
hdl/dds_modulation_top.sv
verification/dds_modulation_sva.sv
verification/dds_modulation_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the dds modulation testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f dds_modulation_top.f \
   --top-module dds_modulation_tb \
   -o dds_modulation_sim

# an assertion can stop the simulator early, the log decides the result
./obj_dir/dds_modulation_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
   exit 0
fi
exit 1

// File: verification/dds_modulation_stim.txt
# name mod_sel wave_sel base_word mark_word samples base_step mark_step
# mod_sel 0 ask 1 fsk 2 bpsk 3 lfsr level, wave_sel 0 sine 1 cosine 2 saw 3 square
saw_fsk     1 2 00300000 00300000   200  3  3
cosine_fsk  1 1 03000000 03000000   200 48 48
square_fsk  1 3 00a00000 00a00000   300 10 10
sine_ask    0 0 00800000 00800000   500  8  8
ask_saw     0 2 01100000 01100000  1500 17 17
bpsk_saw    2 2 00700000 00700000  1500  7  7
fsk_keyed   1 2 00200000 05000000  4000  2 80
lfsr_level  3 2 00400000 00400000 32000  4  4
